//--- bench/xcom_tb.sv
/*
 * Testbench for the board communication block. Reads one test per line
 * from the data file, drives the peripheral port or a second board on
 * channel 1, and checks pulses and returned words. Channel 0 is looped back.
 */
`timescale 1ns/1ps
`default_nettype none
`include "xcom_params.svh"

module xcom_tb;
   import xcom_cmd_pkg::*;

   localparam int CH        = 2;
   localparam int COLS      = 8;
   localparam int MAX_TESTS = 64;
   localparam int FRAME_CYC = `XCOM_FRAME_BITS * `XCOM_BIT_CYC;
   localparam int WAIT_TMO  = 2 * FRAME_CYC + `XCOM_RX_TMO;
   localparam int QUIET_CYC = FRAME_CYC + `XCOM_RX_TMO + 32;
   localparam int CUT_BITS  = 20;

   // Pulse codes in the expected output follow the opcodes
   localparam int EXP_NONE = 0;
   localparam int EXP_ID   = 1;
   localparam int EXP_VLD  = 8;

   logic          c_clk;
   logic          rst_n;
   logic          qp_en;
   xcom_op_e      qp_op;
   logic [31:0]   qp_dt1;
   logic [31:0]   qp_dt2;
   logic          pulse_sync;
   logic          remote_ck;
   logic          remote_dt;
   logic          qp_rdy;
   logic          qp_vld;
   logic          qp_flag;
   logic [31:0]   qp_dt1_out;
   logic [31:0]   qp_dt2_out;
   logic          proc_start;
   logic          proc_stop;
   logic          time_rst;
   logic          time_updt;
   logic [31:0]   time_updt_dt;
   logic          core_start;
   logic          core_stop;
   logic [3:0]    xcom_id;
   logic          xcom_ck;
   logic          xcom_dt;
   logic [CH-1:0] link_ck;
   logic [CH-1:0] link_dt;

   logic [31:0]   tests_mem [MAX_TESTS*COLS];
   int            pulse_cnt [9];
   int            before_cnt [9];
   logic [31:0]   last_updt_dt;
   logic [31:0]   last_dt1;
   logic [31:0]   last_dt2;
   logic          last_flag;
   integer        seed;
   int            test_no;
   int            checks;
   int            errors;
   int            timeouts;

   // Channel 0 loops back and channel 1 is the second board
   assign link_ck = {remote_ck, xcom_ck};
   assign link_dt = {remote_dt, xcom_dt};

   xcom #(
      .CH ( CH )
   ) xcom_inst (
      .c_clk_i        ( c_clk        ),
      .rst_n_i        ( rst_n        ),
      .qp_en_i        ( qp_en        ),
      .qp_op_i        ( qp_op        ),
      .qp_dt1_i       ( qp_dt1       ),
      .qp_dt2_i       ( qp_dt2       ),
      .qp_rdy_o       ( qp_rdy       ),
      .qp_vld_o       ( qp_vld       ),
      .qp_flag_o      ( qp_flag      ),
      .qp_dt1_o       ( qp_dt1_out   ),
      .qp_dt2_o       ( qp_dt2_out   ),
      .pulse_sync_i   ( pulse_sync   ),
      .proc_start_o   ( proc_start   ),
      .proc_stop_o    ( proc_stop    ),
      .time_rst_o     ( time_rst     ),
      .time_updt_o    ( time_updt    ),
      .time_updt_dt_o ( time_updt_dt ),
      .core_start_o   ( core_start   ),
      .core_stop_o    ( core_stop    ),
      .xcom_id_o      ( xcom_id      ),
      .xcom_ck_i      ( link_ck      ),
      .xcom_dt_i      ( link_dt      ),
      .xcom_ck_o      ( xcom_ck      ),
      .xcom_dt_o      ( xcom_dt      )
   );

   initial begin
      c_clk = 1'b0;
      forever #20 c_clk = ~c_clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Pulse monitor sampled on the falling edge
   always @(negedge c_clk) begin
      if (!rst_n) begin
         foreach (pulse_cnt[k]) pulse_cnt[k] = 0;
      end else begin
         if (proc_start) pulse_cnt[2]++;
         if (proc_stop) pulse_cnt[3]++;
         if (time_rst) pulse_cnt[4]++;
         if (core_start) pulse_cnt[6]++;
         if (core_stop) pulse_cnt[7]++;
         if (time_updt) begin
            pulse_cnt[5]++;
            last_updt_dt = time_updt_dt;
         end
         if (qp_vld) begin
            pulse_cnt[8]++;
            last_dt1  = qp_dt1_out;
            last_dt2  = qp_dt2_out;
            last_flag = qp_flag;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   task automatic tick(input int n);
      repeat (n) @(posedge c_clk);
      #2;
   endtask

   function automatic string pulse_name(input int k);
      case (k)
         2:       return "proc_start_o";
         3:       return "proc_stop_o";
         4:       return "time_rst_o";
         5:       return "time_updt_o";
         6:       return "core_start_o";
         7:       return "core_stop_o";
         default: return "qp_vld_o";
      endcase
   endfunction

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] want);
      checks++;
      if (got !== want) begin
         $display("ERROR: test %0d %s = %h, expected %h", test_no, name, got, want);
         errors++;
      end
   endtask

   // Issue a port command and wait until the port is free again
   task automatic port_cmd(input xcom_op_e op, input logic [3:0] dst,
                           input logic [31:0] dt);
      int n;
      n = 0;
      while (!qp_rdy && n < WAIT_TMO) begin
         tick(1);
         n++;
      end
      if (!qp_rdy) begin
         $display("Timeout in test %0d: the port never became ready", test_no);
         timeouts++;
      end
      qp_en  = 1'b1;
      qp_op  = op;
      qp_dt1 = dt;
      qp_dt2 = {28'd0, dst};
      tick(1);
      qp_en = 1'b0;
      check_word("qp_rdy_o", {31'd0, qp_rdy}, 32'd0);
      check_word("qp_flag_o", {31'd0, qp_flag}, 32'd0);
      n = 0;
      while (!qp_rdy && n < WAIT_TMO) begin
         tick(1);
         n++;
      end
      if (!qp_rdy) begin
         $display("Timeout in test %0d: the port stayed busy after a command", test_no);
         timeouts++;
      end else if (op == OP_SET_ID) begin
         check_word("qp_rdy_o low cycles", n, 32'd1);
      end else begin
         checks++;
         if (n <= FRAME_CYC) begin
            $display("ERROR: test %0d qp_rdy_o low cycles = %h, expected more than %h",
                     test_no, n, FRAME_CYC);
            errors++;
         end
      end
   endtask

   // Second board with the same bit timing as the transmitter
   task automatic play_frame(input logic [`XCOM_FRAME_BITS-1:0] frame, input int nbits);
      for (int b = 0; b < nbits; b++) begin
         remote_dt = frame[`XCOM_FRAME_BITS-1-b];
         tick(`XCOM_BIT_CYC / 2);
         remote_ck = ~remote_ck;
         tick(`XCOM_BIT_CYC - `XCOM_BIT_CYC / 2);
      end
      remote_dt = 1'b0;
   endtask

   task automatic sync_pulse();
      pulse_sync = 1'b1;
      tick(1);
      pulse_sync = 1'b0;
   endtask

   task automatic check_result(input int kind, input logic [31:0] val,
                               input logic [3:0] rid);
      int n;
      int want;
      n = 0;
      if (kind == EXP_ID) begin
         check_word("xcom_id_o", {28'd0, xcom_id}, val);
      end else if (kind == EXP_NONE) begin
         tick(QUIET_CYC);
         for (int k = 2; k <= EXP_VLD; k++) begin
            check_word({pulse_name(k), " pulse count"}, pulse_cnt[k] - before_cnt[k], 0);
         end
      end else if (kind > EXP_VLD) begin
         $display("Test %0d asks for an unknown expected output code", test_no);
         errors++;
      end else begin
         while (pulse_cnt[kind] == before_cnt[kind] && n < WAIT_TMO) begin
            tick(1);
            n++;
         end
         if (pulse_cnt[kind] == before_cnt[kind]) begin
            $display("Timeout in test %0d: %s never pulsed", test_no, pulse_name(kind));
            timeouts++;
         end else begin
            // Let a stray second pulse show up
            tick(8);
            for (int k = 2; k <= EXP_VLD; k++) begin
               want = (k == kind) ? 1 : 0;
               check_word({pulse_name(k), " pulse count"}, pulse_cnt[k] - before_cnt[k],
                          want);
            end
            if (kind == 5) check_word("time_updt_dt_o", last_updt_dt, val);
            if (kind == EXP_VLD) begin
               check_word("qp_dt1_o", last_dt1, val);
               check_word("qp_dt2_o", last_dt2, {27'd0, 1'b1, rid});
               check_word("qp_flag_o", {31'd0, last_flag}, 32'd1);
            end
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      int base;
      int n_tests;
      logic [31:0] data;
      logic [31:0] exp_val;
      logic [`XCOM_FRAME_BITS-1:0] frame;
      seed       = 32'had61f20f;
      checks     = 0;
      errors     = 0;
      timeouts   = 0;
      test_no    = 0;
      n_tests    = 0;
      rst_n      = 1'b0;
      qp_en      = 1'b0;
      qp_op      = OP_SET_ID;
      qp_dt1     = '0;
      qp_dt2     = '0;
      pulse_sync = 1'b0;
      remote_ck  = 1'b0;
      remote_dt  = 1'b0;
      $readmemh("bench/xcom_tests.txt", tests_mem);
      tick(10);
      rst_n = 1'b1;
      tick(1);
      check_word("qp_rdy_o", {31'd0, qp_rdy}, 32'd1);
      check_word("xcom_id_o", {28'd0, xcom_id}, 32'd0);
      check_word("qp_flag_o", {31'd0, qp_flag}, 32'd0);
      check_word("xcom_ck_o", {31'd0, xcom_ck}, 32'd0);
      check_word("xcom_dt_o", {31'd0, xcom_dt}, 32'd0);

      while (n_tests < MAX_TESTS && !$isunknown(tests_mem[n_tests*COLS])
             && tests_mem[n_tests*COLS] != 32'hf) begin
         base    = n_tests * COLS;
         test_no = n_tests;
         data    = tests_mem[base+4];
         exp_val = tests_mem[base+7];
         if (tests_mem[base+5][0]) begin
            data    = $random(seed);
            exp_val = data;
         end
         frame = {tests_mem[base+1][3:0], tests_mem[base+2][3:0],
                  tests_mem[base+3][3:0], data};
         before_cnt = pulse_cnt;
         case (tests_mem[base])
            32'h0:   port_cmd(xcom_op_e'(tests_mem[base+1][3:0]),
                              tests_mem[base+2][3:0], data);
            32'h1:   play_frame(frame, `XCOM_FRAME_BITS);
            32'h2:   play_frame(frame, CUT_BITS);
            32'h3:   sync_pulse();
            default: begin
               $display("Test %0d has an unknown stimulus source", test_no);
               errors++;
            end
         endcase
         check_result(int'(tests_mem[base+6]), exp_val, tests_mem[base+3][3:0]);
         n_tests++;
      end

      $display("Tests: %0d, checks: %0d, errors: %0d, timeouts: %0d",
               n_tests, checks, errors, timeouts);
      if (errors == 0 && timeouts == 0 && n_tests > 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/xcom_tests.txt
// src op dst rid data rnd exp val (hex); src 0 port, 1 remote, 2 remote cut off, 3 sync, f end
// rnd 1 draws data and val at random; exp 0 none, 1 board id, 2-7 pulse, 8 returned word
0 1 0 0 000000a5 0 1 00000005
0 3 0 0 00000000 0 3 00000000
0 4 0 0 00000000 0 4 00000000
0 6 0 0 00000000 0 6 00000000
0 7 0 0 00000000 0 7 00000000
0 5 0 0 12345678 0 5 12345678
0 5 5 0 00000000 1 5 00000000
1 8 5 3 cafe0001 0 8 cafe0001
0 6 0 0 00000000 0 6 00000000
1 4 9 3 00000000 0 0 00000000
1 8 9 3 deadbeef 0 0 00000000
0 2 0 0 00000000 0 0 00000000
3 0 0 0 00000000 0 2 00000000
3 0 0 0 00000000 0 0 00000000
2 5 5 3 0badf00d 0 0 00000000
1 7 5 3 00000000 0 7 00000000
1 8 0 7 00000000 1 8 00000000
1 5 5 7 00000000 1 5 00000000
f 0 0 0 00000000 0 0 00000000

//--- run_sim.sh
#!/bin/sh
# Build the xcom testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module xcom_tb -f xcom.f -o xcom_sim \
   > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/xcom_sim > sim.log 2>&1 \
   || { echo "Simulation exited with an error, see sim.log"; exit 1; }
grep -q "Finished with errors" sim.log \
   && { echo "Simulation failed, see sim.log"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }

//--- src/xcom.sv
/*
 * Board communication block, top level. Connects the command unit,
 * the link transmitter, one receiver per channel and the executor.
 */
`timescale 1ns/1ps
`default_nettype none

module xcom #(
   parameter int CH = 2
)(
   input  logic                     c_clk_i,
   input  logic                     rst_n_i,
   // Peripheral port
   input  logic                     qp_en_i,
   input  xcom_cmd_pkg::xcom_op_e   qp_op_i,
   input  logic [31:0]              qp_dt1_i,
   input  logic [31:0]              qp_dt2_i,
   output logic                     qp_rdy_o,
   output logic                     qp_vld_o,
   output logic                     qp_flag_o,
   output logic [31:0]              qp_dt1_o,
   output logic [31:0]              qp_dt2_o,
   // Control
   input  logic                     pulse_sync_i,
   output logic                     proc_start_o,
   output logic                     proc_stop_o,
   output logic                     time_rst_o,
   output logic                     time_updt_o,
   output logic [31:0]              time_updt_dt_o,
   output logic                     core_start_o,
   output logic                     core_stop_o,
   output logic [3:0]               xcom_id_o,
   // Link lines
   input  logic [CH-1:0]            xcom_ck_i,
   input  logic [CH-1:0]            xcom_dt_i,
   output logic                     xcom_ck_o,
   output logic                     xcom_dt_o
);
   import xcom_link_pkg::*;

   xcom_frame_t     tx_frame;
   logic            tx_req;
   logic            tx_busy;
   logic            cmd_acc;
   logic [CH-1:0]   rx_vld;
   xcom_frame_t     rx_frame [CH];

   //////////////////////////////////////////////////////////////////////
   // Command and transmit path
   xcom_cmd cmd_inst (
      .c_clk_i    ( c_clk_i   ),
      .rst_n_i    ( rst_n_i   ),
      .qp_en_i    ( qp_en_i   ),
      .qp_op_i    ( qp_op_i   ),
      .qp_dt1_i   ( qp_dt1_i  ),
      .qp_dt2_i   ( qp_dt2_i  ),
      .tx_busy_i  ( tx_busy   ),
      .qp_rdy_o   ( qp_rdy_o  ),
      .tx_req_o   ( tx_req    ),
      .tx_frame_o ( tx_frame  ),
      .board_id_o ( xcom_id_o ),
      .cmd_acc_o  ( cmd_acc   )
   );

   xcom_tx tx_inst (
      .c_clk_i    ( c_clk_i   ),
      .rst_n_i    ( rst_n_i   ),
      .tx_req_i   ( tx_req    ),
      .tx_frame_i ( tx_frame  ),
      .tx_busy_o  ( tx_busy   ),
      .tx_ck_o    ( xcom_ck_o ),
      .tx_dt_o    ( xcom_dt_o )
   );

   //////////////////////////////////////////////////////////////////////
   // Receive path
   for (genvar i = 0; i < CH; i++) begin : g_rx
      xcom_rx rx_inst (
         .c_clk_i    ( c_clk_i      ),
         .rst_n_i    ( rst_n_i      ),
         .rx_ck_i    ( xcom_ck_i[i] ),
         .rx_dt_i    ( xcom_dt_i[i] ),
         .rx_vld_o   ( rx_vld[i]    ),
         .rx_frame_o ( rx_frame[i]  )
      );
   end

   xcom_exec #(
      .CH ( CH )
   ) exec_inst (
      .c_clk_i        ( c_clk_i        ),
      .rst_n_i        ( rst_n_i        ),
      .rx_vld_i       ( rx_vld         ),
      .rx_frame_i     ( rx_frame       ),
      .board_id_i     ( xcom_id_o      ),
      .cmd_acc_i      ( cmd_acc        ),
      .pulse_sync_i   ( pulse_sync_i   ),
      .proc_start_o   ( proc_start_o   ),
      .proc_stop_o    ( proc_stop_o    ),
      .time_rst_o     ( time_rst_o     ),
      .time_updt_o    ( time_updt_o    ),
      .time_updt_dt_o ( time_updt_dt_o ),
      .core_start_o   ( core_start_o   ),
      .core_stop_o    ( core_stop_o    ),
      .qp_vld_o       ( qp_vld_o       ),
      .qp_flag_o      ( qp_flag_o      ),
      .qp_dt1_o       ( qp_dt1_o       ),
      .qp_dt2_o       ( qp_dt2_o       )
   );

endmodule

`default_nettype wire

//--- src/xcom_cmd.sv
/*
 * Command unit. Accepts peripheral port commands, sets the board id
 * locally and hands every other opcode to the transmitter as a frame.
 */
`timescale 1ns/1ps
`default_nettype none

module xcom_cmd (
   input  logic                         c_clk_i,
   input  logic                         rst_n_i,
   input  logic                         qp_en_i,
   input  xcom_cmd_pkg::xcom_op_e       qp_op_i,
   input  logic [31:0]                  qp_dt1_i,
   input  logic [31:0]                  qp_dt2_i,
   input  logic                         tx_busy_i,
   output logic                         qp_rdy_o,
   output logic                         tx_req_o,
   output xcom_link_pkg::xcom_frame_t   tx_frame_o,
   output logic [3:0]                   board_id_o,
   output logic                         cmd_acc_o
);
   import xcom_cmd_pkg::*;

   typedef enum logic [1:0] {
      CMD_IDLE,
      CMD_SEND,
      CMD_WAIT
   } cmd_state_e;

   cmd_state_e   state_q;
   xcom_cmd_t    cmd_q;
   logic [3:0]   board_id_q;

   assign qp_rdy_o   = (state_q == CMD_IDLE);
   assign cmd_acc_o  = qp_en_i & qp_rdy_o;
   assign tx_req_o   = (state_q == CMD_SEND) && (cmd_q.op != OP_SET_ID);
   assign board_id_o = board_id_q;

   // Source field is always this board
   assign tx_frame_o = '{op: cmd_q.op, dst: cmd_q.dst, src: board_id_q, dt: cmd_q.dt};

   //////////////////////////////////////////////////////////////////////
   // Command latch
   always_ff @(posedge c_clk_i) begin
      if (cmd_acc_o) begin
         cmd_q.op  <= qp_op_i;
         cmd_q.dst <= qp_dt2_i[3:0];
         cmd_q.dt  <= qp_dt1_i;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Idle, send one request, wait for the frame to leave
   always_ff @(posedge c_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= CMD_IDLE;
         board_id_q <= '0;
      end else begin
         case (state_q)
            CMD_IDLE: if (cmd_acc_o) state_q <= CMD_SEND;
            CMD_SEND: begin
               if (cmd_q.op == OP_SET_ID) begin
                  board_id_q <= cmd_q.dt[3:0];
                  state_q    <= CMD_IDLE;
               end else begin
                  state_q <= CMD_WAIT;
               end
            end
            CMD_WAIT: if (!tx_busy_i) state_q <= CMD_IDLE;
            default:  state_q <= CMD_IDLE;
         endcase
      end
   end

   // A new frame is only requested once the transmitter is free
   a_req_not_busy: assert property (@(posedge c_clk_i) disable iff (!rst_n_i)
      $rose(tx_req_o) |-> !tx_busy_i);

endmodule

`default_nettype wire

//--- src/xcom_cmd_pkg.sv
/*
 * Command side types: opcodes issued on the peripheral port and the
 * command word latched by the command unit.
 */
`default_nettype none
`include "xcom_params.svh"

package xcom_cmd_pkg;

   localparam int XCOM_OP_W = 4;
   localparam int XCOM_ID_W = 4;
   // Data is what is left of a frame after op, destination and source
   localparam int XCOM_DT_W = `XCOM_FRAME_BITS - XCOM_OP_W - 2 * XCOM_ID_W;

   typedef enum logic [XCOM_OP_W-1:0] {
      OP_SET_ID     = 4'h1,
      OP_PROC_START = 4'h2,
      OP_PROC_STOP  = 4'h3,
      OP_TIME_RST   = 4'h4,
      OP_TIME_UPDT  = 4'h5,
      OP_CORE_START = 4'h6,
      OP_CORE_STOP  = 4'h7,
      OP_SEND_DT    = 4'h8
   } xcom_op_e;

   // Accepted command, destination 0 is broadcast
   typedef struct packed {
      xcom_op_e               op;
      logic [XCOM_ID_W-1:0]   dst;
      logic [XCOM_DT_W-1:0]   dt;
   } xcom_cmd_t;

endpackage

`default_nettype wire

//--- src/xcom_exec.sv
/*
 * Frame executor. Picks one received frame per cycle, lowest channel
 * first, drops frames for other boards and turns the rest into control
 * pulses or a data word returned on the peripheral port.
 */
`timescale 1ns/1ps
`default_nettype none

module xcom_exec #(
   parameter int CH = 2
)(
   input  logic                         c_clk_i,
   input  logic                         rst_n_i,
   input  logic [CH-1:0]                rx_vld_i,
   input  xcom_link_pkg::xcom_frame_t   rx_frame_i [CH],
   input  logic [3:0]                   board_id_i,
   input  logic                         cmd_acc_i,
   input  logic                         pulse_sync_i,
   output logic                         proc_start_o,
   output logic                         proc_stop_o,
   output logic                         time_rst_o,
   output logic                         time_updt_o,
   output logic [31:0]                  time_updt_dt_o,
   output logic                         core_start_o,
   output logic                         core_stop_o,
   output logic                         qp_vld_o,
   output logic                         qp_flag_o,
   output logic [31:0]                  qp_dt1_o,
   output logic [31:0]                  qp_dt2_o
);
   import xcom_cmd_pkg::*;
   import xcom_link_pkg::*;

   localparam int CH_W = (CH > 1) ? $clog2(CH) : 1;

   logic [CH-1:0]     pend_q;
   xcom_frame_t       pend_frame_q [CH];
   logic [CH-1:0]     cand;
   xcom_frame_t       cand_frame [CH];
   logic              sel_vld;
   logic [CH_W-1:0]   sel_ch;
   xcom_frame_t       sel_frame;
   logic              hit;
   logic              proc_arm_q;

   //////////////////////////////////////////////////////////////////////
   // Channel select, a held frame goes before a new one
   always_comb begin
      sel_vld = 1'b0;
      sel_ch  = '0;
      for (int c = CH - 1; c >= 0; c--) begin
         cand[c]       = pend_q[c] | rx_vld_i[c];
         cand_frame[c] = pend_q[c] ? pend_frame_q[c] : rx_frame_i[c];
         if (cand[c]) begin
            sel_vld = 1'b1;
            sel_ch  = CH_W'(c);
         end
      end
   end

   assign sel_frame = cand_frame[sel_ch];
   assign hit = sel_vld && (sel_frame.dst == 4'd0 || sel_frame.dst == board_id_i);

   always_ff @(posedge c_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pend_q <= '0;
      end else begin
         for (int c = 0; c < CH; c++) begin
            pend_q[c] <= cand[c] && !(sel_vld && sel_ch == CH_W'(c));
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Control pulses and flag
   always_ff @(posedge c_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         proc_arm_q   <= 1'b0;
         proc_start_o <= 1'b0;
         proc_stop_o  <= 1'b0;
         time_rst_o   <= 1'b0;
         time_updt_o  <= 1'b0;
         core_start_o <= 1'b0;
         core_stop_o  <= 1'b0;
         qp_vld_o     <= 1'b0;
         qp_flag_o    <= 1'b0;
      end else begin
         // Program start waits for the sync pulse
         if (hit && sel_frame.op == OP_PROC_START) proc_arm_q <= 1'b1;
         else if (pulse_sync_i) proc_arm_q <= 1'b0;
         proc_start_o <= proc_arm_q & pulse_sync_i;
         proc_stop_o  <= hit && (sel_frame.op == OP_PROC_STOP);
         time_rst_o   <= hit && (sel_frame.op == OP_TIME_RST);
         time_updt_o  <= hit && (sel_frame.op == OP_TIME_UPDT);
         core_start_o <= hit && (sel_frame.op == OP_CORE_START);
         core_stop_o  <= hit && (sel_frame.op == OP_CORE_STOP);
         qp_vld_o     <= hit && (sel_frame.op == OP_SEND_DT);
         if (hit && sel_frame.op == OP_SEND_DT) qp_flag_o <= 1'b1;
         else if (cmd_acc_i) qp_flag_o <= 1'b0;
      end
   end

   // Held frames and returned words
   always_ff @(posedge c_clk_i) begin
      for (int c = 0; c < CH; c++) begin
         if (rx_vld_i[c]) pend_frame_q[c] <= rx_frame_i[c];
      end
      if (hit && sel_frame.op == OP_TIME_UPDT) time_updt_dt_o <= sel_frame.dt;
      if (hit && sel_frame.op == OP_SEND_DT) begin
         qp_dt1_o <= sel_frame.dt;
         // Channel above the source id
         qp_dt2_o <= 32'({sel_ch, sel_frame.src});
      end
   end

endmodule

`default_nettype wire

//--- src/xcom_link_pkg.sv
/*
 * Link side types: the serial frame layout and the receiver states,
 * plus the counter types sized from the link timing.
 */
`default_nettype none
`include "xcom_params.svh"

package xcom_link_pkg;

   // Sent MSB first, so the opcode leads
   typedef struct packed {
      xcom_cmd_pkg::xcom_op_e                 op;
      logic [xcom_cmd_pkg::XCOM_ID_W-1:0]     dst;
      logic [xcom_cmd_pkg::XCOM_ID_W-1:0]     src;
      logic [xcom_cmd_pkg::XCOM_DT_W-1:0]     dt;
   } xcom_frame_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_SHIFT,
      RX_DONE
   } xcom_rx_state_e;

   typedef logic [$clog2(`XCOM_BIT_CYC)-1:0]    xcom_per_cnt_t;
   typedef logic [$clog2(`XCOM_FRAME_BITS)-1:0] xcom_bit_cnt_t;
   typedef logic [$clog2(`XCOM_RX_TMO)-1:0]     xcom_tmo_cnt_t;

endpackage

`default_nettype wire

//--- src/xcom_params.svh
/*
 * Link timing and frame size for the board communication block.
 * Included by the packages and by the link modules.
 */
`ifndef XCOM_PARAMS_SVH
`define XCOM_PARAMS_SVH

// Clock cycles per link bit
`define XCOM_BIT_CYC 4

// Bits per frame: op, destination, source and data
`define XCOM_FRAME_BITS 44

// Idle cycles before a partial frame is dropped
`define XCOM_RX_TMO 64

`endif

//--- src/xcom_rx.sv
/*
 * Link receiver for one channel. Synchronizes the clock and data lines,
 * takes a bit on every clock toggle and flags a full frame for a cycle.
 * A frame that stalls for the timeout is dropped.
 */
`timescale 1ns/1ps
`default_nettype none
`include "xcom_params.svh"

module xcom_rx (
   input  logic                         c_clk_i,
   input  logic                         rst_n_i,
   input  logic                         rx_ck_i,
   input  logic                         rx_dt_i,
   output logic                         rx_vld_o,
   output xcom_link_pkg::xcom_frame_t   rx_frame_o
);
   import xcom_link_pkg::*;

   localparam xcom_bit_cnt_t BIT_LAST = xcom_bit_cnt_t'(`XCOM_FRAME_BITS - 1);
   localparam xcom_tmo_cnt_t TMO_LAST = xcom_tmo_cnt_t'(`XCOM_RX_TMO - 1);

   logic [2:0]                   ck_sync_q;
   logic [1:0]                   dt_sync_q;
   logic                         ck_edge;
   xcom_rx_state_e               state_q;
   xcom_bit_cnt_t                bit_cnt_q;
   xcom_tmo_cnt_t                tmo_q;
   logic [`XCOM_FRAME_BITS-1:0]  shift_q;

   //////////////////////////////////////////////////////////////////////
   // Two flop synchronizers, third clock flop for the toggle
   always_ff @(posedge c_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ck_sync_q <= '0;
         dt_sync_q <= '0;
      end else begin
         ck_sync_q <= {ck_sync_q[1:0], rx_ck_i};
         dt_sync_q <= {dt_sync_q[0], rx_dt_i};
      end
   end

   // Either direction of the line clock is a bit
   assign ck_edge = ck_sync_q[2] ^ ck_sync_q[1];

   always_ff @(posedge c_clk_i) begin
      if (ck_edge) shift_q <= {shift_q[`XCOM_FRAME_BITS-2:0], dt_sync_q[1]};
   end

   //////////////////////////////////////////////////////////////////////
   // Frame FSM
   always_ff @(posedge c_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= RX_IDLE;
         bit_cnt_q <= '0;
         tmo_q     <= '0;
      end else begin
         case (state_q)
            // A frame may start right after the previous one
            RX_IDLE, RX_DONE: begin
               state_q   <= RX_IDLE;
               bit_cnt_q <= '0;
               tmo_q     <= '0;
               if (ck_edge) begin
                  state_q   <= RX_SHIFT;
                  bit_cnt_q <= xcom_bit_cnt_t'(1);
               end
            end
            RX_SHIFT: begin
               if (ck_edge) begin
                  tmo_q     <= '0;
                  bit_cnt_q <= bit_cnt_q + 1'b1;
                  if (bit_cnt_q == BIT_LAST) state_q <= RX_DONE;
               end else if (tmo_q == TMO_LAST) begin
                  state_q <= RX_IDLE;
               end else begin
                  tmo_q <= tmo_q + 1'b1;
               end
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

   assign rx_vld_o   = (state_q == RX_DONE);
   assign rx_frame_o = shift_q;

   a_vld_single: assert property (@(posedge c_clk_i) disable iff (!rst_n_i)
      rx_vld_o |=> !rx_vld_o);

endmodule

`default_nettype wire

//--- src/xcom_tx.sv
/*
 * Link transmitter. Shifts a frame out MSB first: each bit is put on
 * the data line, then the clock line toggles half a bit period later.
 */
`timescale 1ns/1ps
`default_nettype none
`include "xcom_params.svh"

module xcom_tx (
   input  logic                         c_clk_i,
   input  logic                         rst_n_i,
   input  logic                         tx_req_i,
   input  xcom_link_pkg::xcom_frame_t   tx_frame_i,
   output logic                         tx_busy_o,
   output logic                         tx_ck_o,
   output logic                         tx_dt_o
);
   import xcom_link_pkg::*;

   localparam xcom_per_cnt_t PER_HALF = xcom_per_cnt_t'(`XCOM_BIT_CYC / 2);
   localparam xcom_per_cnt_t PER_LAST = xcom_per_cnt_t'(`XCOM_BIT_CYC - 1);
   localparam xcom_bit_cnt_t BIT_LAST = xcom_bit_cnt_t'(`XCOM_FRAME_BITS - 1);

   logic                         busy_q;
   xcom_per_cnt_t                per_cnt_q;
   xcom_bit_cnt_t                bit_cnt_q;
   logic [`XCOM_FRAME_BITS-1:0]  shift_q;

   assign tx_busy_o = busy_q;

   //////////////////////////////////////////////////////////////////////
   // Bit timing and line outputs
   always_ff @(posedge c_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q    <= 1'b0;
         per_cnt_q <= '0;
         bit_cnt_q <= '0;
         tx_ck_o   <= 1'b0;
         tx_dt_o   <= 1'b0;
      end else if (!busy_q) begin
         per_cnt_q <= '0;
         bit_cnt_q <= '0;
         tx_dt_o   <= 1'b0;
         if (tx_req_i) busy_q <= 1'b1;
      end else begin
         per_cnt_q <= per_cnt_q + 1'b1;
         // Data first, clock edge mid-bit
         if (per_cnt_q == '0) tx_dt_o <= shift_q[`XCOM_FRAME_BITS-1];
         if (per_cnt_q == PER_HALF) tx_ck_o <= ~tx_ck_o;
         if (per_cnt_q == PER_LAST) begin
            per_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == BIT_LAST) busy_q <= 1'b0;
         end
      end
   end

   // Frame shifter
   always_ff @(posedge c_clk_i) begin
      if (!busy_q && tx_req_i) begin
         shift_q <= tx_frame_i;
      end else if (busy_q && per_cnt_q == PER_LAST) begin
         shift_q <= {shift_q[`XCOM_FRAME_BITS-2:0], 1'b0};
      end
   end

   // Line clock is quiet between frames
   a_ck_in_frame: assert property (@(posedge c_clk_i) disable iff (!rst_n_i)
      $changed(tx_ck_o) |-> $past(busy_q));

endmodule

`default_nettype wire

//--- xcom.f
+incdir+src
src/xcom_cmd_pkg.sv
src/xcom_link_pkg.sv
src/xcom_cmd.sv
src/xcom_tx.sv
src/xcom_rx.sv
src/xcom_exec.sv
src/xcom.sv
bench/xcom_tb.sv
